// File: k051960_pkg.sv
// Shared constants and types for the 051960 video timing and CPU register core
// Imported by the design modules and by the testbench checker
`default_nettype none

package k051960_pkg;

	// Video timing
	localparam int H_TOTAL       = 384; // Clocks per line
	localparam int V_TOTAL       = 264; // Lines per frame
	localparam int V_BLANK_START = 240;
	localparam int NMI_LINES     = 32;
	localparam int NMI_DIV_W     = $clog2(NMI_LINES);
	localparam int H_W           = 9;
	localparam int V_W           = 9;

	// CPU bus and ROM address
	localparam int ADDR_W         = 11;
	localparam int DATA_W         = 8;
	localparam int CA_W           = 18;
	localparam int ROM_WINDOW_BIT = 10; // High half of the chip's space

	// Control register 0 bits
	localparam int IRQ_EN_BIT   = 0;
	localparam int FIRQ_EN_BIT  = 1;
	localparam int NMI_EN_BIT   = 2;
	localparam int FLIP_BIT     = 3;
	localparam int ROM_READ_BIT = 5;

	// Register picked by ab[2:0] while ab[10:3] is zero
	typedef enum logic [3:0] {
		REG_CTRL    = 4'd0,
		REG_BANK_LO = 4'd2,
		REG_BANK_HI = 4'd3,
		REG_NONE    = 4'hf
	} reg_sel_t;

endpackage

`default_nettype wire

// File: k051960_ifs.sv
// Internal interfaces of the 051960 core
// ctrl_regs_if carries control register 0 out of cpu_regs, video_timing_if the line timing
`timescale 1ns/10ps
`default_nettype none

interface ctrl_regs_if;
	logic irq_en;
	logic firq_en;
	logic nmi_en;
	logic flip;
	logic rom_read; // CPU reads graphics ROM

	modport regs (
		output irq_en, firq_en, nmi_en, flip, rom_read
	);

	modport irq (
		input irq_en, firq_en, nmi_en
	);

	modport video (
		input flip
	);
endinterface

interface video_timing_if
	import k051960_pkg::*;
();
	logic           line_start; // First clock of a line
	logic [V_W-1:0] vcount;     // Not flipped
	logic           vblank;
	logic           frame_end;

	modport source (
		output line_start, vcount, vblank, frame_end
	);

	modport sink (
		input line_start, vcount, vblank, frame_end
	);
endinterface

`default_nettype wire

// File: video_counter.sv
// Horizontal and vertical video counters with external frame sync
// Produces the line timing for the interrupt and register blocks
`timescale 1ns/10ps
`default_nettype none

module video_counter
	import k051960_pkg::*;
(
	input  wire            clk_6M,
	input  wire            V143,
	input  wire            hvin,
	output logic [H_W-1:0] hp,
	output logic [7:0]     vp,
	output logic           hend,
	output logic           hvot,
	ctrl_regs_if.video     ctrl,
	video_timing_if.source timing
);

	logic           sync_q;
	logic [V_W-1:0] vcnt;
	logic           last_line;

	// Single register in place of the chip's HVIN delay line
	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			sync_q <= 1'b0;
		end else begin
			sync_q <= ~hvin;
		end
	end

	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			hp <= '0;
		end else if (sync_q) begin
			hp <= '0;
		end else if (hend) begin
			hp <= '0;
		end else begin
			hp <= hp + 1'b1;
		end
	end

	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			vcnt <= '0;
		end else if (sync_q) begin
			vcnt <= '0;
		end else if (hend) begin
			if (last_line) begin
				vcnt <= '0;
			end else begin
				vcnt <= vcnt + 1'b1;
			end
		end
	end

	assign hend      = (hp == H_W'(H_TOTAL - 1));
	assign last_line = (vcnt == V_W'(V_TOTAL - 1));
	assign hvot      = hend & last_line;

	// Inverted under flip, as for the sprite line compare
	assign vp = vcnt[7:0] ^ {8{ctrl.flip}};

	assign timing.line_start = (hp == '0);
	assign timing.vcount     = vcnt;
	assign timing.vblank     = (vcnt >= V_W'(V_BLANK_START));
	assign timing.frame_end  = hvot;

endmodule

`default_nettype wire

// File: cpu_regs.sv
// CPU register interface: control register 0, ROM bank registers and ROM readback
// Writes take effect on the clock edge, reads and the ROM address are combinational
`timescale 1ns/10ps
`default_nettype none

module cpu_regs
	import k051960_pkg::*;
(
	input  wire               clk_6M,
	input  wire               V143,
	input  wire               cs_n,
	input  wire               wr_n,
	input  wire               rd_n,
	input  wire [ADDR_W-1:0]  ab,
	input  wire [DATA_W-1:0]  db_in,
	input  wire [DATA_W-1:0]  rom_data,
	output logic [DATA_W-1:0] db_out,
	output logic              db_dir,
	output logic [CA_W-1:0]   ca,
	ctrl_regs_if.regs         ctrl,
	video_timing_if.sink      timing
);

	reg_sel_t          sel;
	logic              wr;
	logic              rd;
	logic              status_rd;
	logic              rom_rd;
	logic [DATA_W-1:0] bank_lo;
	logic [1:0]        bank_hi; // Only two bits reach CA

	always_comb begin
		sel = REG_NONE;
		if (ab[ADDR_W-1:3] == '0) begin
			case (ab[2:0])
				3'd0:    sel = REG_CTRL;
				3'd2:    sel = REG_BANK_LO;
				3'd3:    sel = REG_BANK_HI;
				default: sel = REG_NONE;
			endcase
		end
	end

	assign wr = ~cs_n & ~wr_n;
	assign rd = ~cs_n & ~rd_n;

	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			ctrl.irq_en   <= 1'b0;
			ctrl.firq_en  <= 1'b0;
			ctrl.nmi_en   <= 1'b0;
			ctrl.flip     <= 1'b0;
			ctrl.rom_read <= 1'b0;
		end else if (wr && sel == REG_CTRL) begin
			ctrl.irq_en   <= db_in[IRQ_EN_BIT];
			ctrl.firq_en  <= db_in[FIRQ_EN_BIT];
			ctrl.nmi_en   <= db_in[NMI_EN_BIT];
			ctrl.flip     <= db_in[FLIP_BIT];
			ctrl.rom_read <= db_in[ROM_READ_BIT];
		end
	end

	always_ff @(posedge clk_6M) begin
		if (wr && sel == REG_BANK_LO) begin
			bank_lo <= db_in;
		end
		if (wr && sel == REG_BANK_HI) begin
			bank_hi <= db_in[1:0];
		end
	end

	assign status_rd = rd & (sel == REG_CTRL);
	assign rom_rd    = rd & ab[ROM_WINDOW_BIT] & ctrl.rom_read;

	// Render address is not modelled, so CA idles at zero
	assign ca = ctrl.rom_read ? {bank_hi, bank_lo, ab[ROM_WINDOW_BIT-1:2]} : '0;

	always_comb begin
		if (rom_rd) begin
			db_out = rom_data;
		end else if (status_rd) begin
			db_out = {timing.vblank, {(DATA_W - 1){1'b0}}};
		end else begin
			db_out = '0;
		end
	end

	assign db_dir = rom_rd | status_rd; // Chip drives the data bus

endmodule

`default_nettype wire

// File: irq_ctrl.sv
// IRQ, FIRQ and NMI generation from the line timing
// Each line latches low on its event and is released by clearing its enable bit
`timescale 1ns/10ps
`default_nettype none

module irq_ctrl
	import k051960_pkg::*;
(
	input  wire          clk_6M,
	input  wire          V143,
	ctrl_regs_if.irq     ctrl,
	video_timing_if.sink timing,
	output logic         irq_n,
	output logic         firq_n,
	output logic         nmi_n
);

	logic [NMI_DIV_W-1:0] nmi_div;
	logic                 first_line;
	logic [2:0]           en;
	logic [2:0]           ev;
	logic [2:0]           pend;

	assign first_line = (timing.vcount == '0);

	// Line divider for NMI, restarted at line 0 after an external resync
	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			nmi_div <= '0;
		end else if (timing.frame_end) begin
			nmi_div <= '0;
		end else if (timing.line_start) begin
			nmi_div <= first_line ? NMI_DIV_W'(1) : nmi_div + 1'b1;
		end
	end

	assign en = {ctrl.nmi_en, ctrl.firq_en, ctrl.irq_en};

	assign ev[0] = timing.line_start & (timing.vcount == V_W'(V_BLANK_START));
	assign ev[1] = timing.line_start & ~timing.vcount[0]; // Even lines
	assign ev[2] = timing.line_start & (first_line | (nmi_div == '0));

	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			pend <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!en[i]) begin
					pend[i] <= 1'b0; // Held clear while disabled
				end else if (ev[i]) begin
					pend[i] <= 1'b1;
				end
			end
		end
	end

	assign irq_n  = ~pend[0];
	assign firq_n = ~pend[1];
	assign nmi_n  = ~pend[2];

endmodule

`default_nettype wire

// File: k051960_core.sv
// Top level of the reduced 051960: video counters, CPU registers and interrupts
// Plain chip pins outside, internal interfaces between the blocks
`timescale 1ns/10ps
`default_nettype none

module k051960_core
	import k051960_pkg::*;
(
	input  wire               clk_6M,
	input  wire               V143,
	input  wire               hvin,
	input  wire               cs_n,
	input  wire               wr_n,
	input  wire               rd_n,
	input  wire [ADDR_W-1:0]  ab,
	input  wire [DATA_W-1:0]  db_in,
	input  wire [DATA_W-1:0]  rom_data,
	output logic [DATA_W-1:0] db_out,
	output logic              db_dir,
	output logic [CA_W-1:0]   ca,
	output logic [H_W-1:0]    hp,
	output logic [7:0]        vp,
	output logic              vblank,
	output logic              hend,
	output logic              hvot,
	output logic              irq_n,
	output logic              firq_n,
	output logic              nmi_n
);

	ctrl_regs_if    ctrl_if ();
	video_timing_if timing_if ();

	video_counter u_video (
		.clk_6M (clk_6M),
		.V143   (V143),
		.hvin   (hvin),
		.hp     (hp),
		.vp     (vp),
		.hend   (hend),
		.hvot   (hvot),
		.ctrl   (ctrl_if.video),
		.timing (timing_if.source)
	);

	cpu_regs u_regs (
		.clk_6M   (clk_6M),
		.V143     (V143),
		.cs_n     (cs_n),
		.wr_n     (wr_n),
		.rd_n     (rd_n),
		.ab       (ab),
		.db_in    (db_in),
		.rom_data (rom_data),
		.db_out   (db_out),
		.db_dir   (db_dir),
		.ca       (ca),
		.ctrl     (ctrl_if.regs),
		.timing   (timing_if.sink)
	);

	irq_ctrl u_irq (
		.clk_6M (clk_6M),
		.V143   (V143),
		.ctrl   (ctrl_if.irq),
		.timing (timing_if.sink),
		.irq_n  (irq_n),
		.firq_n (firq_n),
		.nmi_n  (nmi_n)
	);

	assign vblank = timing_if.vblank;

endmodule

`default_nettype wire

// File: k051960_properties.sv
// Assertions bound into k051960_core for strobe widths and IRQ release
`timescale 1ns/10ps
`default_nettype none

module k051960_properties (
	input wire clk_6M,
	input wire V143,
	input wire hend,
	input wire hvot,
	input wire irq_n,
	input wire irq_en
);

	int fails = 0; // Failed assertion count

	hend_single: assert property (@(posedge clk_6M) disable iff (!V143) hend |=> !hend)
		else begin
			fails++;
			$error("hend high for more than one clock");
		end

	hvot_single: assert property (@(posedge clk_6M) disable iff (!V143) hvot |=> !hvot)
		else begin
			fails++;
			$error("hvot high for more than one clock");
		end

	hvot_in_hend: assert property (@(posedge clk_6M) disable iff (!V143) hvot |-> hend)
		else begin
			fails++;
			$error("hvot high without hend");
		end

	irq_release: assert property (@(posedge clk_6M) disable iff (!V143) !irq_en |=> irq_n)
		else begin
			fails++;
			$error("irq_n still low one clock after irq_en cleared");
		end

endmodule

bind k051960_core k051960_properties props (
	.clk_6M (clk_6M),
	.V143   (V143),
	.hend   (hend),
	.hvot   (hvot),
	.irq_n  (irq_n),
	.irq_en (ctrl_if.irq_en)
);

`default_nettype wire

// File: tb_checker.sv
// Checker for k051960_core: keeps its own model of counters, registers and interrupts
// Compares every DUT output on each rising clock edge and counts mismatches
`timescale 1ns/10ps
`default_nettype none

module tb_checker
	import k051960_pkg::*;
(
	input  wire              clk_6M,
	input  wire              V143,
	input  wire              hvin,
	input  wire              cs_n,
	input  wire              wr_n,
	input  wire              rd_n,
	input  wire [ADDR_W-1:0] ab,
	input  wire [DATA_W-1:0] db_in,
	input  wire [DATA_W-1:0] db_out,
	input  wire              db_dir,
	input  wire [CA_W-1:0]   ca,
	input  wire [H_W-1:0]    hp,
	input  wire [7:0]        vp,
	input  wire              vblank,
	input  wire              hend,
	input  wire              hvot,
	input  wire              irq_n,
	input  wire              firq_n,
	input  wire              nmi_n,
	input  wire [2:0]        phase,
	output int               checks,
	output int               errors
);

	logic [H_W-1:0]    m_hp;
	logic [V_W-1:0]    m_line;
	logic              m_sync;
	logic [DATA_W-1:0] m_ctrl;
	logic [DATA_W-1:0] m_bank_lo;
	logic [DATA_W-1:0] m_bank_hi;
	logic [2:0]        m_pend; // NMI, FIRQ, IRQ pending

	initial begin
		checks = 0;
		errors = 0;
	end

	function automatic string test_name(input logic [2:0] p);
		case (p)
			3'd0:    return "reset";
			3'd1:    return "video_timing";
			3'd2:    return "readback";
			3'd3:    return "irq";
			3'd4:    return "firq_nmi";
			default: return "flip";
		endcase
	endfunction

	function automatic reg_sel_t sel_ref(input logic [ADDR_W-1:0] addr);
		case (addr)
			ADDR_W'(0): return REG_CTRL;
			ADDR_W'(2): return REG_BANK_LO;
			ADDR_W'(3): return REG_BANK_HI;
			default:    return REG_NONE;
		endcase
	endfunction

	function automatic logic vblank_ref(input logic [V_W-1:0] line);
		return line >= V_BLANK_START;
	endfunction

	function automatic logic [7:0] vp_ref(input logic [V_W-1:0] line, input logic flip);
		return flip ? ~line[7:0] : line[7:0];
	endfunction

	function automatic logic [CA_W-1:0] ca_ref(input logic [DATA_W-1:0] ctrl,
			input logic [DATA_W-1:0] lo, input logic [DATA_W-1:0] hi,
			input logic [ADDR_W-1:0] addr);
		if (!ctrl[ROM_READ_BIT]) begin
			return '0;
		end
		return {hi[1:0], lo, addr[ROM_WINDOW_BIT-1:2]};
	endfunction

	function automatic logic [DATA_W-1:0] rom_ref(input logic [CA_W-1:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {6'b0, addr[17:16]};
	endfunction

	// Next pending state: set on the line event, cleared while disabled
	function automatic logic [2:0] pend_ref(input logic [2:0] pend,
			input logic [DATA_W-1:0] ctrl, input logic [V_W-1:0] line,
			input logic [H_W-1:0] pos);
		logic [2:0] ev;
		logic [2:0] en;
		ev[0] = (pos == 0) && (line == V_BLANK_START);
		ev[1] = (pos == 0) && !line[0];
		ev[2] = (pos == 0) && (line % NMI_LINES == 0);
		en    = {ctrl[NMI_EN_BIT], ctrl[FIRQ_EN_BIT], ctrl[IRQ_EN_BIT]};
		return en & (pend | ev);
	endfunction

	task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: %s expected %0h actual %0h at %0t",
				test_name(phase), sig, exp, act, $time);
		end
	endtask

	always @(posedge clk_6M) begin : check_cycle
		logic            rd;
		logic            rom_rd;
		logic            stat_rd;
		logic [CA_W-1:0] exp_ca;
		if (!V143) begin
			m_hp   = '0;
			m_line = '0;
			m_sync = 1'b0;
			m_ctrl = '0;
			m_pend = '0;
		end else begin
			rd      = !cs_n && !rd_n;
			exp_ca  = ca_ref(m_ctrl, m_bank_lo, m_bank_hi, ab);
			rom_rd  = rd && ab[ROM_WINDOW_BIT] && m_ctrl[ROM_READ_BIT];
			stat_rd = rd && (sel_ref(ab) == REG_CTRL);
			compare("hp", m_hp, hp);
			compare("hend", m_hp == H_TOTAL - 1, hend);
			compare("hvot", (m_hp == H_TOTAL - 1) && (m_line == V_TOTAL - 1), hvot);
			compare("vblank", vblank_ref(m_line), vblank);
			compare("vp", vp_ref(m_line, m_ctrl[FLIP_BIT]), vp);
			compare("ca", exp_ca, ca);
			compare("db_dir", rom_rd || stat_rd, db_dir);
			if (rom_rd) begin
				compare("db_out rom", rom_ref(exp_ca), db_out);
			end
			if (stat_rd) begin
				compare("db_out status", {vblank_ref(m_line), 7'b0}, db_out);
			end
			compare("irq_n", !m_pend[0], irq_n);
			compare("firq_n", !m_pend[1], firq_n);
			compare("nmi_n", !m_pend[2], nmi_n);

			m_pend = pend_ref(m_pend, m_ctrl, m_line, m_hp);
			if (m_sync) begin
				m_hp   = '0;
				m_line = '0;
			end else if (m_hp == H_TOTAL - 1) begin
				m_hp   = '0;
				m_line = (m_line == V_TOTAL - 1) ? '0 : m_line + 1'b1;
			end else begin
				m_hp = m_hp + 1'b1;
			end
			m_sync = !hvin; // Frame sync register
			if (!cs_n && !wr_n) begin
				case (sel_ref(ab))
					REG_CTRL:    m_ctrl = db_in;
					REG_BANK_LO: m_bank_lo = db_in;
					REG_BANK_HI: m_bank_hi = db_in;
					default:     ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_k051960.sv
// Testbench top for k051960_core with clock, reset, CPU bus stimulus and ROM model
// Runs the video, readback and interrupt sequences while tb_checker compares
`timescale 1ns/10ps
`default_nettype none

module tb_k051960
	import k051960_pkg::*;
();

	localparam int     CLK_PERIOD   = 8;
	localparam int     FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam longint WATCHDOG_NS  = 64'd4 * FRAME_CYCLES * CLK_PERIOD; // Four frames

	logic              clk_6M;
	logic              V143;
	logic              hvin;
	logic              cs_n;
	logic              wr_n;
	logic              rd_n;
	logic [ADDR_W-1:0] ab;
	logic [DATA_W-1:0] db_in;
	logic [DATA_W-1:0] rom_data;
	logic [DATA_W-1:0] db_out;
	logic              db_dir;
	logic [CA_W-1:0]   ca;
	logic [H_W-1:0]    hp;
	logic [7:0]        vp;
	logic              vblank;
	logic              hend;
	logic              hvot;
	logic              irq_n;
	logic              firq_n;
	logic              nmi_n;
	logic [2:0]        phase;
	int                checks;
	int                errors;
	int                tb_errors;
	logic [DATA_W-1:0] ctrl_val; // Copy of control register 0

	always #(CLK_PERIOD / 2) clk_6M = ~clk_6M;

	// Graphics ROM contents, every byte of the address folded in
	function automatic logic [DATA_W-1:0] rom_byte(input logic [CA_W-1:0] addr);
		return addr[7:0] ^ addr[15:8] ^ {6'b0, addr[17:16]};
	endfunction

	assign rom_data = rom_byte(ca);

	k051960_core dut (.*);

	tb_checker chk (.*);

	task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(negedge clk_6M);
		cs_n  = 1'b0;
		wr_n  = 1'b0;
		ab    = addr;
		db_in = data;
		@(negedge clk_6M);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic cpu_read(input logic [ADDR_W-1:0] addr);
		@(negedge clk_6M);
		cs_n = 1'b0;
		rd_n = 1'b0;
		ab   = addr;
		@(negedge clk_6M);
		cs_n = 1'b1;
		rd_n = 1'b1;
	endtask

	task automatic pulse_hvin();
		@(negedge clk_6M);
		hvin = 1'b0;
		@(negedge clk_6M);
		hvin = 1'b1;
	endtask

	// 0 frame end, 1 IRQ low, other FIRQ or NMI low
	task automatic wait_for(input int which, input int max_cycles, input string what);
		int n;
		bit seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < max_cycles) begin
			@(negedge clk_6M);
			case (which)
				0:       seen = hvot;
				1:       seen = !irq_n;
				default: seen = !firq_n || !nmi_n;
			endcase
			n++;
		end
		if (!seen) begin
			$display("No %s within %0d clocks", what, max_cycles);
			tb_errors++;
		end
	endtask

	initial begin
		int                firq_seen;
		int                nmi_seen;
		logic [DATA_W-1:0] mask;
		void'($urandom(32'h0fe1_0296));
		clk_6M    = 1'b0;
		V143      = 1'b0;
		hvin      = 1'b1;
		cs_n      = 1'b1;
		wr_n      = 1'b1;
		rd_n      = 1'b1;
		ab        = '0;
		db_in     = '0;
		phase     = 3'd0;
		ctrl_val  = '0;
		tb_errors = 0;
		firq_seen = 0;
		nmi_seen  = 0;
		repeat (5) @(posedge clk_6M);
		@(negedge clk_6M);
		V143 = 1'b1;
		repeat (20) @(negedge clk_6M);

		phase = 3'd1;
		wait_for(0, FRAME_CYCLES + 16, "frame end");
		repeat (100) @(negedge clk_6M);
		pulse_hvin(); // Restart mid-line
		repeat (2 * H_TOTAL) @(negedge clk_6M);

		phase = 3'd2;
		for (int b = 0; b < 4; b++) begin
			cpu_write(ADDR_W'(2), DATA_W'($urandom));
			cpu_write(ADDR_W'(3), DATA_W'($urandom));
			ctrl_val[ROM_READ_BIT] = 1'b1;
			cpu_write('0, ctrl_val);
			repeat (8) cpu_read({1'b1, 10'($urandom)});
		end
		ctrl_val[ROM_READ_BIT] = 1'b0;
		cpu_write('0, ctrl_val);
		repeat (4) cpu_read({1'b1, 10'($urandom)}); // No readback, no bus drive
		cpu_read('0);

		phase = 3'd3;
		ctrl_val[IRQ_EN_BIT] = 1'b1;
		cpu_write('0, ctrl_val);
		wait_for(1, FRAME_CYCLES + 16, "IRQ");
		cpu_read('0); // Status inside vblank
		ctrl_val[IRQ_EN_BIT] = 1'b0;
		cpu_write('0, ctrl_val);
		repeat (4) @(negedge clk_6M);

		phase = 3'd4;
		ctrl_val[FIRQ_EN_BIT] = 1'b1;
		ctrl_val[NMI_EN_BIT]  = 1'b1;
		cpu_write('0, ctrl_val);
		for (int i = 0; i < 100 && nmi_seen < 2 && tb_errors == 0; i++) begin
			wait_for(2, 3 * H_TOTAL, "FIRQ or NMI");
			mask = '0;
			if (!firq_n) begin
				mask[FIRQ_EN_BIT] = 1'b1;
				firq_seen++;
			end
			if (!nmi_n) begin
				mask[NMI_EN_BIT] = 1'b1;
				nmi_seen++;
			end
			cpu_write('0, ctrl_val & ~mask);
			cpu_write('0, ctrl_val);
		end
		if (nmi_seen < 2 || firq_seen < 2) begin
			$display("Too few interrupts seen: %0d FIRQ, %0d NMI", firq_seen, nmi_seen);
			tb_errors++;
		end
		ctrl_val[FIRQ_EN_BIT] = 1'b0;
		ctrl_val[NMI_EN_BIT]  = 1'b0;
		cpu_write('0, ctrl_val);

		phase = 3'd5;
		ctrl_val[FLIP_BIT] = 1'b1;
		cpu_write('0, ctrl_val);
		repeat (3 * H_TOTAL) @(negedge clk_6M);
		ctrl_val[FLIP_BIT] = 1'b0;
		cpu_write('0, ctrl_val);
		repeat (H_TOTAL) @(negedge clk_6M);

		if (checks == 0) begin
			$display("Checker compared nothing");
			tb_errors++;
		end
		$display("Checks: %0d compared, %0d mismatches, %0d assertion failures, %0d other failures",
			checks, errors, dut.props.fails, tb_errors);
		if (errors == 0 && tb_errors == 0 && dut.props.fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, test sequence did not complete", $time);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
k051960_pkg.sv
k051960_ifs.sv
video_counter.sv
cpu_regs.sv
irq_ctrl.sv
k051960_core.sv
k051960_properties.sv
tb_checker.sv
tb_k051960.sv

// File: Bender.yml
package:
  name: k051960_core

sources:
  - k051960_pkg.sv
  - k051960_ifs.sv
  - video_counter.sv
  - cpu_regs.sv
  - irq_ctrl.sv
  - k051960_core.sv
  - target: test
    files:
      - k051960_properties.sv
      - tb_checker.sv
      - tb_k051960.sv
